//--- dv/aluPipeTb.sv
`timescale 1ns/1ps

module aluPipeTb;

	localparam int QueueDepth    = 4;
	localparam int OutCredits    = 2;
	localparam int TimeoutCycles = 200;

	// r-type functs without jr, i-type opcodes, unknown encodings
	localparam logic [5:0] RFuncts [10] = '{6'h20, 6'h22, 6'h18, 6'h24, 6'h25,
		6'h27, 6'h26, 6'h00, 6'h02, 6'h2a};
	localparam logic [5:0] IOps [8] = '{6'h08, 6'h0a, 6'h23, 6'h2b, 6'h0c, 6'h0d,
		6'h0e, 6'h0f};
	localparam logic [5:0] BadOps [4] = '{6'h02, 6'h04, 6'h09, 6'h3f};
	localparam logic [5:0] BadFuncts [4] = '{6'h01, 6'h03, 6'h21, 6'h3f};

	logic             clk;
	logic             arstN;
	logic             inValid;
	aluPkg::instrReqS inReq;
	logic             outCredit;
	logic             inCredit;
	logic             outValid;
	aluPkg::resultS   outRes;

	// expected results in send order
	aluPkg::resultS expQ [$];
	aluPkg::resultS expHead;

	string                       curTest;
	int                          stimSeed;
	int                          rcvSeed;
	logic [31:0]                 rcvRnd;
	logic [aluPkg::TagWidth-1:0] nextTag;
	// sender side
	int senderCredits;
	int inCreditSeen;
	// receiver side
	int   received;
	int   returned;
	int   owed;
	int   delayMax;
	int   delayCnt;
	logic holdCredits;

	tbClock #(
		.Period     (40),
		.ResetCycles(3)
	) i_clock (
		.clk  (clk),
		.arstN(arstN)
	);

	aluPipeTop #(
		.QueueDepth(QueueDepth),
		.OutCredits(OutCredits)
	) i_dut (
		.clk      (clk),
		.arstN    (arstN),
		.inValid  (inValid),
		.inReq    (inReq),
		.outCredit(outCredit),
		.inCredit (inCredit),
		.outValid (outValid),
		.outRes   (outRes)
	);

	task automatic stopWithFailure(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkEq(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			stopWithFailure($sformatf("CHECK FAILED %s expected %0h actual %0h",
				name, expected, actual));
		end
	endtask

	// expected record straight from the mips encoding
	function automatic aluPkg::resultS computeExpected(input aluPkg::instrReqS req);
		aluPkg::resultS res;
		logic [31:0]    a;
		logic [31:0]    b;
		logic [31:0]    sext;
		logic [31:0]    zext;
		logic [4:0]     sh;
		a           = req.rsValue;
		b           = req.rtValue;
		sext        = {{16{req.instr[15]}}, req.instr[15:0]};
		zext        = {16'h0000, req.instr[15:0]};
		sh          = req.instr[10:6];
		res.tag     = req.tag;
		res.illegal = 1'b0;
		res.result  = '0;
		// i-type writes rt
		res.destReg = req.instr[20:16];
		case (req.instr[31:26])
			6'h00: begin
				res.destReg = req.instr[15:11];
				case (req.instr[5:0])
					6'h20: res.result = a + b;
					6'h22: res.result = a - b;
					6'h18: res.result = a * b;
					6'h24: res.result = a & b;
					6'h25: res.result = a | b;
					6'h27: res.result = ~(a | b);
					6'h26: res.result = a ^ b;
					6'h00: res.result = b << sh;
					6'h02: res.result = b >> sh;
					6'h2a: res.result = {31'b0, $signed(a) < $signed(b)};
					6'h08: begin
						res.result  = a;
						res.destReg = '0;
					end
					default: res.illegal = 1'b1;
				endcase
			end
			// addi and lw
			6'h08, 6'h23: res.result = a + sext;
			6'h2b: begin
				res.result  = a + sext;
				res.destReg = '0;
			end
			6'h0a: res.result = {31'b0, $signed(a) < $signed(sext)};
			6'h0c: res.result = a & zext;
			6'h0d: res.result = a | zext;
			6'h0e: res.result = a ^ zext;
			6'h0f: res.result = {req.instr[15:0], 16'h0000};
			default: res.illegal = 1'b1;
		endcase
		// illegal gives an empty record
		if (res.illegal) begin
			res.result  = '0;
			res.destReg = '0;
		end
		return res;
	endfunction

	task automatic waitSendCredit();
		int t;
		t = 0;
		while (senderCredits == 0) begin
			@(posedge clk);
			#2;
			t++;
			if (t > TimeoutCycles) begin
				stopWithFailure("timeout waiting for an input credit");
			end
		end
	endtask

	// puts one request on the bus and books its result
	task automatic driveReq(input logic [31:0] instr, input logic [31:0] rsVal,
		input logic [31:0] rtVal);
		aluPkg::instrReqS req;
		req.instr   = instr;
		req.rsValue = rsVal;
		req.rtValue = rtVal;
		req.tag     = nextTag;
		nextTag     = nextTag + 1'b1;
		inReq       = req;
		inValid     = 1'b1;
		expQ.push_back(computeExpected(req));
		senderCredits--;
	endtask

	task automatic sendReq(input logic [31:0] instr, input logic [31:0] rsVal,
		input logic [31:0] rtVal);
		waitSendCredit();
		driveReq(instr, rsVal, rtVal);
		@(posedge clk);
		#2;
		inValid = 1'b0;
	endtask

	// random rs, rt, rd and shamt fields
	task automatic sendR(input logic [5:0] funct, input logic [31:0] rsVal,
		input logic [31:0] rtVal);
		logic [31:0] rnd;
		rnd = $random(stimSeed);
		sendReq({6'h00, rnd[19:5], rnd[4:0], funct}, rsVal, rtVal);
	endtask

	task automatic sendI(input logic [5:0] opcode, input logic [15:0] imm,
		input logic [31:0] rsVal);
		logic [31:0] rnd;
		rnd = $random(stimSeed);
		sendReq({opcode, rnd[9:0], imm}, rsVal, $random(stimSeed));
	endtask

	task automatic waitDrained();
		int t;
		t = 0;
		while (expQ.size() != 0 || owed != 0) begin
			@(posedge clk);
			#2;
			t++;
			if (t > TimeoutCycles) begin
				stopWithFailure($sformatf("timeout in %s, results still missing", curTest));
			end
		end
	endtask

	// receiver hands each consumed credit back after a random delay
	initial begin
		outCredit = 1'b0;
		delayCnt  = 0;
		forever begin
			@(posedge clk);
			#2;
			outCredit = 1'b0;
			if (owed > 0 && !holdCredits) begin
				if (delayCnt == 0) begin
					outCredit = 1'b1;
					owed--;
					returned++;
					rcvRnd   = $random(rcvSeed);
					delayCnt = int'(rcvRnd % 32'(delayMax + 1));
				end else begin
					delayCnt--;
				end
			end
		end
	end

	// outputs are stable mid cycle
	always @(negedge clk) begin
		if (arstN) begin
			if (inCredit) begin
				inCreditSeen++;
				senderCredits++;
			end
			if (outValid) begin
				received++;
				if (received > OutCredits + returned) begin
					stopWithFailure("result sent without an output credit");
				end
				if (expQ.size() == 0) begin
					stopWithFailure("result arrived with no request outstanding");
				end
				expHead = expQ.pop_front();
				checkEq(curTest, 64'(expHead), 64'(outRes));
				owed++;
			end
		end
	end

	initial begin
		logic [31:0] rnd;
		logic [31:0] rnd2;
		int          t;
		int          cycles;
		int          sent;
		int          creditBase;
		int          recvBase;
		inValid       = 1'b0;
		inReq         = '0;
		curTest       = "reset";
		stimSeed      = 91539;
		rcvSeed       = 91539;
		nextTag       = '0;
		senderCredits = QueueDepth;
		inCreditSeen  = 0;
		received      = 0;
		returned      = 0;
		owed          = 0;
		delayMax      = 0;
		holdCredits   = 1'b0;
		t             = 0;
		while (arstN !== 1'b1) begin
			@(posedge clk);
			#2;
			t++;
			if (t > TimeoutCycles) begin
				stopWithFailure("reset never released");
			end
		end

		// r-type on random operands
		curTest  = "rtype";
		delayMax = 2;
		for (int i = 0; i < 10; i++) begin
			for (int n = 0; n < 4; n++) begin
				rnd  = $random(stimSeed);
				rnd2 = $random(stimSeed);
				sendR(RFuncts[i], rnd, rnd2);
			end
		end
		// slt across the sign boundary
		sendR(6'h2a, 32'hffff_fff0, 32'h0000_0005);
		sendR(6'h2a, 32'h0000_0005, 32'hffff_fff0);
		sendR(6'h2a, 32'h8000_0000, 32'h7fff_ffff);
		sendR(6'h2a, 32'hffff_fffe, 32'hffff_ffff);
		waitDrained();

		// odd i-type passes get a negative immediate
		curTest  = "itype";
		delayMax = 0;
		for (int i = 0; i < 8; i++) begin
			for (int n = 0; n < 4; n++) begin
				rnd     = $random(stimSeed);
				rnd[15] = (n % 2 == 1);
				sendI(IOps[i], rnd[15:0], $random(stimSeed));
			end
		end
		waitDrained();

		curTest  = "jr and illegal";
		delayMax = 3;
		repeat (3) sendR(6'h08, $random(stimSeed), $random(stimSeed));
		for (int i = 0; i < 4; i++) begin
			rnd  = $random(stimSeed);
			rnd2 = $random(stimSeed);
			sendI(BadOps[i], rnd[15:0], rnd2);
			sendR(BadFuncts[i], rnd, rnd2);
		end
		waitDrained();

		// single add into an idle pipe
		curTest  = "latency";
		delayMax = 0;
		waitSendCredit();
		driveReq({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h20}, 32'd7, 32'd9);
		cycles = 0;
		while (cycles == 0 || !outValid) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > TimeoutCycles) begin
				stopWithFailure("timeout waiting for outValid in latency test");
			end
			#1;
			if (cycles == 1) begin
				inValid = 1'b0;
			end
		end
		checkEq("latency cycles", 64'd4, 64'(cycles));
		waitDrained();

		// receiver withholds credits so the queue fills
		curTest     = "backpressure";
		delayMax    = 1;
		holdCredits = 1'b1;
		sent        = 0;
		creditBase  = inCreditSeen;
		recvBase    = received;
		repeat (24) begin
			if (senderCredits > 0) begin
				rnd  = $random(stimSeed);
				rnd2 = $random(stimSeed);
				sendR(RFuncts[sent % 10], rnd, rnd2);
				sent++;
			end else begin
				@(posedge clk);
				#2;
			end
		end
		checkEq("backpressure sender credits", 64'd0, 64'(senderCredits));
		checkEq("backpressure outputs under hold", 64'(OutCredits), 64'(received - recvBase));
		checkEq("backpressure requests accepted", 64'(QueueDepth + OutCredits), 64'(sent));
		holdCredits = 1'b0;
		waitDrained();
		checkEq("backpressure input credits", 64'(sent), 64'(inCreditSeen - creditBase));
		checkEq("backpressure credits restored", 64'(QueueDepth), 64'(senderCredits));

		$display("Done: no errors");
		$finish;
	end

endmodule

//--- dv/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int Period      = 40,
	parameter int ResetCycles = 3
) (
	output logic clk,
	output logic arstN
);

	// free running clock
	initial begin
		clk = 1'b0;
		forever #(Period / 2) clk = ~clk;
	end

	// reset low for a few edges, released off the edge
	initial begin
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		#2;
		arstN = 1'b1;
	end

endmodule

//--- project.f
source/aluPkg.sv
source/instrQueue.sv
source/issueStage.sv
source/aluControl.sv
source/executeStage.sv
source/aluPipeTop.sv
dv/tbClock.sv
dv/aluPipeTb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -Wno-fatal -f project.f --top-module aluPipeTb \
	> build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/ValuPipeTb > sim.log 2>&1 || true
cat sim.log

grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

//--- source/aluControl.sv
`timescale 1ns/1ps

module aluControl (
	input  logic            clk,
	input  logic            arstN,
	input  logic            decValid,
	input  aluPkg::decodedS decoded,
	output logic            ctrlValid,
	output aluPkg::ctrlS    ctrl
);

	aluPkg::aluFuncE funcNext;

	always_comb begin
		case (decoded.aluOp)
			// r-type, funct code picks the function
			aluPkg::opRType: begin
				case (decoded.funct)
					6'b100000: funcNext = aluPkg::fnAdd;
					6'b100010: funcNext = aluPkg::fnSub;
					6'b011000: funcNext = aluPkg::fnMul;
					6'b100100: funcNext = aluPkg::fnAnd;
					6'b100101: funcNext = aluPkg::fnOr;
					6'b100111: funcNext = aluPkg::fnNor;
					6'b100110: funcNext = aluPkg::fnXor;
					6'b000000: funcNext = aluPkg::fnSll;
					6'b000010: funcNext = aluPkg::fnSrl;
					6'b101010: funcNext = aluPkg::fnSlt;
					6'b001000: funcNext = aluPkg::fnJr;
					// unlisted funct
					default:   funcNext = aluPkg::fnIllegal;
				endcase
			end
			// i-type ops map one to one
			aluPkg::opAdd: funcNext = aluPkg::fnAdd;
			aluPkg::opAnd: funcNext = aluPkg::fnAnd;
			aluPkg::opOr:  funcNext = aluPkg::fnOr;
			aluPkg::opXor: funcNext = aluPkg::fnXor;
			aluPkg::opSlt: funcNext = aluPkg::fnSlt;
			aluPkg::opLui: funcNext = aluPkg::fnLui;
			default:       funcNext = aluPkg::fnIllegal;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			ctrlValid <= 1'b0;
		end else begin
			ctrlValid <= decValid;
		end
	end

	always_ff @(posedge clk) begin
		if (decValid) begin
			ctrl.aluFunc <= funcNext;
			ctrl.shamt   <= decoded.shamt;
			ctrl.opA     <= decoded.opA;
			ctrl.opB     <= decoded.opB;
			ctrl.tag     <= decoded.tag;
			// jr writes no register
			ctrl.destReg <= (funcNext == aluPkg::fnJr) ? 5'd0 : decoded.destReg;
		end
	end

endmodule

//--- source/aluPipeTop.sv
`timescale 1ns/1ps

module aluPipeTop #(
	parameter int QueueDepth = 4,
	parameter int OutCredits = 2
) (
	input  logic             clk,
	input  logic             arstN,
	input  logic             inValid,
	input  aluPkg::instrReqS inReq,
	input  logic             outCredit,
	output logic             inCredit,
	output logic             outValid,
	output aluPkg::resultS   outRes
);

	// queue to issue
	aluPkg::instrReqS head;
	logic             notEmpty;
	logic             pop;

	// issue to control to execute
	logic             decValid;
	aluPkg::decodedS  decoded;
	logic             ctrlValid;
	aluPkg::ctrlS     ctrl;

	instrQueue #(
		.QueueDepth(QueueDepth)
	) i_instrQueue (
		.clk     (clk),
		.arstN   (arstN),
		.inValid (inValid),
		.inReq   (inReq),
		.pop     (pop),
		.head    (head),
		.notEmpty(notEmpty),
		.inCredit(inCredit)
	);

	issueStage #(
		.OutCredits(OutCredits)
	) i_issueStage (
		.clk      (clk),
		.arstN    (arstN),
		.head     (head),
		.notEmpty (notEmpty),
		.outCredit(outCredit),
		.pop      (pop),
		.decValid (decValid),
		.decoded  (decoded)
	);

	aluControl i_aluControl (
		.clk      (clk),
		.arstN    (arstN),
		.decValid (decValid),
		.decoded  (decoded),
		.ctrlValid(ctrlValid),
		.ctrl     (ctrl)
	);

	executeStage i_executeStage (
		.clk      (clk),
		.arstN    (arstN),
		.ctrlValid(ctrlValid),
		.ctrl     (ctrl),
		.outValid (outValid),
		.outRes   (outRes)
	);

endmodule

//--- source/aluPkg.sv
package aluPkg;

	// operand and result width
	parameter int DataWidth = 32;
	// request tag width
	parameter int TagWidth = 8;

	// main decode result, one per opcode group
	typedef enum logic [2:0] {
		opRType,
		opAdd,
		opAnd,
		opOr,
		opXor,
		opSlt,
		opLui,
		opIllegal
	} aluOpE;

	// alu function, r-type members carry the mips funct code
	typedef enum logic [5:0] {
		fnSll     = 6'b000000,
		fnSrl     = 6'b000010,
		fnJr      = 6'b001000,
		fnLui     = 6'b001111,
		fnMul     = 6'b011000,
		fnAdd     = 6'b100000,
		fnSub     = 6'b100010,
		fnAnd     = 6'b100100,
		fnOr      = 6'b100101,
		fnXor     = 6'b100110,
		fnNor     = 6'b100111,
		fnSlt     = 6'b101010,
		fnIllegal = 6'b111111
	} aluFuncE;

	// request as seen by the queue
	typedef struct packed {
		logic [31:0]          instr;
		logic [DataWidth-1:0] rsValue;
		logic [DataWidth-1:0] rtValue;
		logic [TagWidth-1:0]  tag;
	} instrReqS;

	// issue stage output
	typedef struct packed {
		aluOpE                aluOp;
		logic [5:0]           funct;
		logic [4:0]           shamt;
		logic [DataWidth-1:0] opA;
		// rt value or extended immediate
		logic [DataWidth-1:0] opB;
		logic [4:0]           destReg;
		logic [TagWidth-1:0]  tag;
	} decodedS;

	// alu control output, funct and op folded into aluFunc
	typedef struct packed {
		aluFuncE              aluFunc;
		logic [4:0]           shamt;
		logic [DataWidth-1:0] opA;
		logic [DataWidth-1:0] opB;
		logic [4:0]           destReg;
		logic [TagWidth-1:0]  tag;
	} ctrlS;

	// one result record
	typedef struct packed {
		logic [DataWidth-1:0] result;
		logic [4:0]           destReg;
		logic [TagWidth-1:0]  tag;
		logic                 illegal;
	} resultS;

endpackage

//--- source/executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input  logic           clk,
	input  logic           arstN,
	input  logic           ctrlValid,
	input  aluPkg::ctrlS   ctrl,
	output logic           outValid,
	output aluPkg::resultS outRes
);

	logic [aluPkg::DataWidth-1:0] resNext;
	logic                         illegalNext;
	logic                         sltBit;

	// signed compare for slt and slti
	assign sltBit = $signed(ctrl.opA) < $signed(ctrl.opB);

	always_comb begin
		illegalNext = 1'b0;
		case (ctrl.aluFunc)
			aluPkg::fnAdd: resNext = ctrl.opA + ctrl.opB;
			aluPkg::fnSub: resNext = ctrl.opA - ctrl.opB;
			// low half of the product only
			aluPkg::fnMul: resNext = ctrl.opA * ctrl.opB;
			aluPkg::fnAnd: resNext = ctrl.opA & ctrl.opB;
			aluPkg::fnOr:  resNext = ctrl.opA | ctrl.opB;
			aluPkg::fnNor: resNext = ~(ctrl.opA | ctrl.opB);
			aluPkg::fnXor: resNext = ctrl.opA ^ ctrl.opB;
			// shifts work on rt by shamt
			aluPkg::fnSll: resNext = ctrl.opB << ctrl.shamt;
			aluPkg::fnSrl: resNext = ctrl.opB >> ctrl.shamt;
			aluPkg::fnSlt: resNext = {{(aluPkg::DataWidth - 1){1'b0}}, sltBit};
			// jr hands back rs
			aluPkg::fnJr:  resNext = ctrl.opA;
			// lui immediate already shifted at issue
			aluPkg::fnLui: resNext = ctrl.opB;
			default: begin
				resNext     = '0;
				illegalNext = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= ctrlValid;
		end
	end

	// result record, loaded only with a valid item
	always_ff @(posedge clk) begin
		if (ctrlValid) begin
			outRes.result  <= resNext;
			outRes.tag     <= ctrl.tag;
			outRes.illegal <= illegalNext;
			// illegal result writes nothing
			outRes.destReg <= illegalNext ? 5'd0 : ctrl.destReg;
		end
	end

	// function chosen upstream must be known whenever an item is valid
	assert property (@(posedge clk) disable iff (!arstN)
		ctrlValid |-> !$isunknown(ctrl.aluFunc))
	else $error("executeStage: unknown alu function on a valid item");

endmodule

//--- source/instrQueue.sv
`timescale 1ns/1ps

module instrQueue #(
	parameter int QueueDepth = 4
) (
	input  logic             clk,
	input  logic             arstN,
	input  logic             inValid,
	input  aluPkg::instrReqS inReq,
	input  logic             pop,
	output aluPkg::instrReqS head,
	output logic             notEmpty,
	output logic             inCredit
);

	// pointer width, at least one bit for a single entry
	localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
	localparam int CntWidth = $clog2(QueueDepth + 1);

	// storage, no reset on payload
	aluPkg::instrReqS mem [QueueDepth];

	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CntWidth-1:0] count;

	// head is read straight from storage
	assign head     = mem[rdPtr];
	assign notEmpty = (count != '0);

	always_ff @(posedge clk) begin
		if (inValid) begin
			mem[wrPtr] <= inReq;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			count    <= '0;
			inCredit <= 1'b0;
		end else begin
			// wrap by compare, depth need not be a power of two
			if (inValid) begin
				wrPtr <= (wrPtr == PtrWidth'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == PtrWidth'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			// simultaneous write and pop leaves count alone
			case ({inValid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back per freed slot, a cycle late
			inCredit <= pop;
		end
	end

	// sender must respect its credits, so no write into a full buffer
	assert property (@(posedge clk) disable iff (!arstN)
		!(inValid && (count == CntWidth'(QueueDepth)) && !pop))
	else $error("instrQueue: write while full");

endmodule

//--- source/issueStage.sv
`timescale 1ns/1ps

module issueStage #(
	parameter int OutCredits = 2
) (
	input  logic             clk,
	input  logic             arstN,
	input  aluPkg::instrReqS head,
	input  logic             notEmpty,
	input  logic             outCredit,
	output logic             pop,
	output logic             decValid,
	output aluPkg::decodedS  decoded
);

	localparam int CrdWidth = $clog2(OutCredits + 1);

	logic [CrdWidth-1:0] creditCnt;
	aluPkg::decodedS     decNext;

	// instruction fields
	logic [5:0]  opcode;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [15:0] imm;

	assign opcode = head.instr[31:26];
	assign rt     = head.instr[20:16];
	assign rd     = head.instr[15:11];
	assign imm    = head.instr[15:0];

	// issue only with an output credit in hand
	assign pop = notEmpty && (creditCnt != '0);

	always_comb begin
		decNext.funct = head.instr[5:0];
		decNext.shamt = head.instr[10:6];
		decNext.opA   = head.rsValue;
		decNext.tag   = head.tag;
		decNext.opB   = head.rtValue;
		decNext.destReg = rt;
		case (opcode)
			// r-type, funct decides later
			6'b000000: begin
				decNext.aluOp   = aluPkg::opRType;
				decNext.destReg = rd;
			end
			// addi, lw: sign extended add
			6'b001000, 6'b100011: begin
				decNext.aluOp = aluPkg::opAdd;
				decNext.opB   = {{(aluPkg::DataWidth - 16){imm[15]}}, imm};
			end
			// sw writes no register
			6'b101011: begin
				decNext.aluOp   = aluPkg::opAdd;
				decNext.opB     = {{(aluPkg::DataWidth - 16){imm[15]}}, imm};
				decNext.destReg = 5'd0;
			end
			// slti
			6'b001010: begin
				decNext.aluOp = aluPkg::opSlt;
				decNext.opB   = {{(aluPkg::DataWidth - 16){imm[15]}}, imm};
			end
			// andi, ori, xori take zero extension
			6'b001100: begin
				decNext.aluOp = aluPkg::opAnd;
				decNext.opB   = {{(aluPkg::DataWidth - 16){1'b0}}, imm};
			end
			6'b001101: begin
				decNext.aluOp = aluPkg::opOr;
				decNext.opB   = {{(aluPkg::DataWidth - 16){1'b0}}, imm};
			end
			6'b001110: begin
				decNext.aluOp = aluPkg::opXor;
				decNext.opB   = {{(aluPkg::DataWidth - 16){1'b0}}, imm};
			end
			// lui, immediate into the upper half
			6'b001111: begin
				decNext.aluOp = aluPkg::opLui;
				decNext.opB   = aluPkg::DataWidth'({imm, 16'h0000});
			end
			default: begin
				decNext.aluOp   = aluPkg::opIllegal;
				decNext.destReg = 5'd0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			creditCnt <= CrdWidth'(OutCredits);
			decValid  <= 1'b0;
		end else begin
			// pop and return in one cycle cancel out
			case ({pop, outCredit})
				2'b10:   creditCnt <= creditCnt - 1'b1;
				2'b01:   creditCnt <= creditCnt + 1'b1;
				default: creditCnt <= creditCnt;
			endcase
			decValid <= pop;
		end
	end

	// payload, loaded on pop only
	always_ff @(posedge clk) begin
		if (pop) begin
			decoded <= decNext;
		end
	end

	// receiver never returns more than it granted, counter stays in range
	assert property (@(posedge clk) disable iff (!arstN)
		(creditCnt <= CrdWidth'(OutCredits)) &&
		!(outCredit && !pop && (creditCnt == CrdWidth'(OutCredits))))
	else $error("issueStage: output credit counter out of range");

endmodule
